/* src/fetch_pkg.sv */
// Fetch front end shared definitions
// Widths, table geometry, exception causes and the start address
package fetch_pkg;

    ////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] count_t;
    typedef logic [3:0]  cause_t;

    // RISC-V exception codes raised by fetch
    localparam cause_t CAUSE_MISALIGNED   = 4'd0;
    localparam cause_t CAUSE_ACCESS_FAULT = 4'd1;

    // First fetch address out of reset
    localparam addr_t RESET_VECTOR = 32'h0000_0100;
    // addi x0, x0, 0
    localparam word_t NOP_INSTR    = 32'h0000_0013;

    ////////////////////////////////////////
    // Table geometry
    ////////////////////////////////////////
    // Instruction cache, one word per line
    // Index is PC[5:2], tag is PC[31:6]
    localparam int IC_LINES = 16;
    localparam int IC_IDX_W = $clog2(IC_LINES);
    localparam int IC_TAG_W = 32 - IC_IDX_W - 2;
    typedef logic [IC_IDX_W-1:0] ic_idx_t;
    typedef logic [IC_TAG_W-1:0] ic_tag_t;

    // Branch target buffer
    // Index is PC[4:2], tag is PC[31:5]
    localparam int BTB_LINES = 8;
    localparam int BTB_IDX_W = $clog2(BTB_LINES);
    localparam int BTB_TAG_W = 32 - BTB_IDX_W - 2;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;
    // Two-bit saturating counter, MSB set means taken
    typedef logic [1:0] bp_cnt_t;

    // Refill FSM
    typedef enum logic [1:0] {IDLE, REQ, WAIT} icache_state_e;

endpackage

/* src/fetch_intf.sv */
// Fetch front end internal interfaces
// Cache lookup between fetch and icache, predictor update from execute

interface icache_lookup_if
    import fetch_pkg::*;
();
    // Driven by fetch
    addr_t pc;
    logic  lookup_en;
    logic  inval;
    // Driven by the cache, same cycle as the lookup
    logic  hit;
    word_t instr;
    logic  fault;

    modport requester (
        output pc, lookup_en, inval,
        input  hit, instr, fault
    );

    modport responder (
        input  pc, lookup_en, inval,
        output hit, instr, fault
    );
endinterface

interface bp_update_if
    import fetch_pkg::*;
();
    // One-cycle update strobe, no handshake
    logic  valid;
    addr_t pc;
    logic  taken;
    addr_t target;
    logic  is_branch;

    modport sender (output valid, pc, taken, target, is_branch);

    modport receiver (input valid, pc, taken, target, is_branch);
endinterface

/* src/branch_predictor.sv */
// Branch predictor
// Direct-mapped BTB with a 2-bit counter per entry, trained from execute
module branch_predictor
    import fetch_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  addr_t         pc_i,
    output logic          pred_taken_o,
    output addr_t         pred_target_o,
    bp_update_if.receiver upd
);

    // Entry storage
    logic [BTB_LINES-1:0] btb_valid_q;
    btb_tag_t             btb_tag_q    [BTB_LINES];
    addr_t                btb_target_q [BTB_LINES];
    bp_cnt_t              btb_cnt_q    [BTB_LINES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic     wr_match;

    ////////////////////////////////////////
    // Prediction
    ////////////////////////////////////////
    assign rd_idx = pc_i[BTB_IDX_W+1:2];
    assign rd_tag = pc_i[31:BTB_IDX_W+2];

    // Taken on a valid tag match with counter in the upper half
    assign pred_taken_o  = btb_valid_q[rd_idx] && (btb_tag_q[rd_idx] == rd_tag)
                           && btb_cnt_q[rd_idx][1];
    assign pred_target_o = btb_target_q[rd_idx];

    ////////////////////////////////////////
    // Update
    ////////////////////////////////////////
    assign wr_idx   = upd.pc[BTB_IDX_W+1:2];
    assign wr_tag   = upd.pc[31:BTB_IDX_W+2];
    assign wr_match = btb_valid_q[wr_idx] && (btb_tag_q[wr_idx] == wr_tag);

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            btb_valid_q <= '0;
        end else if (upd.valid) begin
            if (upd.is_branch) begin
                btb_valid_q[wr_idx] <= 1'b1;
            end else if (wr_match) begin
                // Non-branch at a predicted PC, drop the stale entry
                btb_valid_q[wr_idx] <= 1'b0;
            end
        end
    end

    // Tag, target and counter
    always_ff @(posedge clk_i) begin
        if (upd.valid && upd.is_branch) begin
            if (wr_match) begin
                if (upd.taken) begin
                    if (btb_cnt_q[wr_idx] != 2'd3) begin
                        btb_cnt_q[wr_idx] <= btb_cnt_q[wr_idx] + 2'd1;
                    end
                    btb_target_q[wr_idx] <= upd.target;
                end else if (btb_cnt_q[wr_idx] != 2'd0) begin
                    btb_cnt_q[wr_idx] <= btb_cnt_q[wr_idx] - 2'd1;
                end
            end else begin
                // Allocate, weakly biased toward the first outcome
                btb_tag_q[wr_idx]    <= wr_tag;
                btb_target_q[wr_idx] <= upd.target;
                btb_cnt_q[wr_idx]    <= upd.taken ? 2'd2 : 2'd1;
            end
        end
    end

endmodule

/* src/icache.sv */
// Instruction cache
// Direct-mapped, one word per line, single-word refill over valid/ready
// Keeps hit and miss counts
module icache
    import fetch_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    icache_lookup_if.responder lk,

    // Memory request channel
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output addr_t              mem_req_addr_o,

    // Memory response channel
    input  logic               mem_rsp_valid_i,
    output logic               mem_rsp_ready_o,
    input  word_t              mem_rsp_data_i,
    input  logic               mem_rsp_error_i,

    // Performance counts
    output count_t             hit_count_o,
    output count_t             miss_count_o
);

    // Line storage
    logic [IC_LINES-1:0] line_valid_q;
    ic_tag_t             line_tag_q  [IC_LINES];
    word_t               line_data_q [IC_LINES];

    icache_state_e state_q;
    icache_state_e state_d;
    // Address of the line being refilled
    addr_t         miss_addr_q;
    count_t        hit_count_q;
    count_t        miss_count_q;

    ic_idx_t lk_idx;
    ic_tag_t lk_tag;
    ic_idx_t fill_idx;
    logic    line_hit;
    logic    miss_start;
    logic    rsp_fire;
    logic    fill_we;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////
    assign lk_idx   = lk.pc[IC_IDX_W+1:2];
    assign lk_tag   = lk.pc[31:IC_IDX_W+2];
    assign line_hit = line_valid_q[lk_idx] && (line_tag_q[lk_idx] == lk_tag);

    assign lk.hit   = lk.lookup_en && line_hit;
    assign lk.instr = line_data_q[lk_idx];

    // Error response for the line being looked up replaces the hit
    // A refill for an older PC never reports here
    assign rsp_fire = (state_q == WAIT) && mem_rsp_valid_i;
    assign lk.fault = lk.lookup_en && rsp_fire && mem_rsp_error_i
                      && (miss_addr_q == lk.pc);

    ////////////////////////////////////////
    // Refill FSM
    ////////////////////////////////////////
    // Only start from IDLE, one request in flight
    assign miss_start = (state_q == IDLE) && lk.lookup_en && !line_hit;
    assign fill_we    = rsp_fire && !mem_rsp_error_i;
    assign fill_idx   = miss_addr_q[IC_IDX_W+1:2];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (miss_start) state_d = REQ;
            REQ: if (mem_req_ready_i) state_d = WAIT;
            WAIT: if (mem_rsp_valid_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign mem_req_valid_o = (state_q == REQ);
    assign mem_req_addr_o  = miss_addr_q;
    assign mem_rsp_ready_o = (state_q == WAIT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            hit_count_q  <= '0;
            miss_count_q <= '0;
            line_valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (lk.hit) begin
                hit_count_q <= hit_count_q + count_t'(1);
            end
            // Counted once per entry into REQ
            if (miss_start) begin
                miss_count_q <= miss_count_q + count_t'(1);
            end
            // Invalidate wins over a refill landing in the same cycle
            if (lk.inval) begin
                line_valid_q <= '0;
            end else if (fill_we) begin
                line_valid_q[fill_idx] <= 1'b1;
            end
        end
    end

    // Miss address and line payload
    always_ff @(posedge clk_i) begin
        if (miss_start) begin
            miss_addr_q <= lk.pc;
        end
        if (fill_we) begin
            line_tag_q[fill_idx]  <= miss_addr_q[31:IC_IDX_W+2];
            line_data_q[fill_idx] <= mem_rsp_data_i;
        end
    end

    assign hit_count_o  = hit_count_q;
    assign miss_count_o = miss_count_q;

endmodule

/* src/fetch_stage.sv */
// Fetch stage
// PC register, next-PC selection, fetch exceptions and the IF/ID register
module fetch_stage
    import fetch_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               hold_i,
    input  logic               flush_i,
    input  logic               inval_i,
    input  logic               redirect_en_i,
    input  addr_t              redirect_pc_i,
    icache_lookup_if.requester ic,
    bp_update_if.receiver      upd,

    // IF/ID register toward decode
    output logic               if_valid_o,
    output addr_t              if_pc_o,
    output word_t              if_instr_o,
    output logic               if_exc_o,
    output cause_t             if_cause_o
);

    addr_t  pc_q;
    addr_t  pc_d;
    logic   pred_taken;
    addr_t  pred_target;
    // Set by a fetch exception, cleared by redirect
    logic   halt_q;
    logic   fetch_go;
    logic   mis_exc;
    logic   exc;
    logic   accept;
    cause_t exc_cause;

    branch_predictor i_branch_predictor (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pc_i         (pc_q),
        .pred_taken_o (pred_taken),
        .pred_target_o(pred_target),
        .upd          (upd)
    );

    ////////////////////////////////////////
    // Lookup and exceptions
    ////////////////////////////////////////
    // No fetch while decode is full, on flush or redirect, or after a fault
    assign fetch_go = !hold_i && !flush_i && !redirect_en_i && !halt_q;

    // Word aligned PCs only
    assign mis_exc = fetch_go && (pc_q[1:0] != 2'b00);

    assign ic.pc        = pc_q;
    assign ic.lookup_en = fetch_go && (pc_q[1:0] == 2'b00);
    assign ic.inval     = inval_i;

    assign exc       = mis_exc || ic.fault;
    assign exc_cause = mis_exc ? CAUSE_MISALIGNED : CAUSE_ACCESS_FAULT;
    assign accept    = ic.hit || exc;

    // Redirect, then prediction for the accepted PC, then sequential
    always_comb begin
        if (redirect_en_i) begin
            pc_d = redirect_pc_i;
        end else if (accept && !exc) begin
            pc_d = pred_taken ? pred_target : pc_q + 32'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q       <= RESET_VECTOR;
            halt_q     <= 1'b0;
            if_valid_o <= 1'b0;
            if_exc_o   <= 1'b0;
        end else begin
            pc_q <= pc_d;
            if (redirect_en_i) begin
                halt_q <= 1'b0;
            end else if (exc) begin
                halt_q <= 1'b1;
            end
            // IF/ID control, flush kills even under hold
            if (flush_i) begin
                if_valid_o <= 1'b0;
                if_exc_o   <= 1'b0;
            end else if (accept) begin
                if_valid_o <= 1'b1;
                if_exc_o   <= exc;
            end else if (!hold_i) begin
                if_valid_o <= 1'b0;
                if_exc_o   <= 1'b0;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            if_pc_o    <= pc_q;
            if_instr_o <= exc ? NOP_INSTR : ic.instr;
            if_cause_o <= exc_cause;
        end
    end

endmodule

/* src/fetch_top.sv */
// Fetch front end top level
// Connects the fetch stage to the instruction cache and the memory port
module fetch_top
    import fetch_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,

    // Pipeline control
    input  logic   hold_i,
    input  logic   flush_i,
    input  logic   inval_i,
    input  logic   redirect_en_i,
    input  addr_t  redirect_pc_i,

    // Predictor training from execute
    input  logic   bp_valid_i,
    input  addr_t  bp_pc_i,
    input  logic   bp_taken_i,
    input  addr_t  bp_target_i,
    input  logic   bp_is_branch_i,

    // Memory port
    output logic   mem_req_valid_o,
    input  logic   mem_req_ready_i,
    output addr_t  mem_req_addr_o,
    input  logic   mem_rsp_valid_i,
    output logic   mem_rsp_ready_o,
    input  word_t  mem_rsp_data_i,
    input  logic   mem_rsp_error_i,

    // Toward decode
    output logic   if_valid_o,
    output addr_t  if_pc_o,
    output word_t  if_instr_o,
    output logic   if_exc_o,
    output cause_t if_cause_o,

    output count_t hit_count_o,
    output count_t miss_count_o
);

    icache_lookup_if ic_if ();
    bp_update_if     bp_if ();

    assign bp_if.valid     = bp_valid_i;
    assign bp_if.pc        = bp_pc_i;
    assign bp_if.taken     = bp_taken_i;
    assign bp_if.target    = bp_target_i;
    assign bp_if.is_branch = bp_is_branch_i;

    fetch_stage i_fetch_stage (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .hold_i       (hold_i),
        .flush_i      (flush_i),
        .inval_i      (inval_i),
        .redirect_en_i(redirect_en_i),
        .redirect_pc_i(redirect_pc_i),
        .ic           (ic_if),
        .upd          (bp_if),
        .if_valid_o   (if_valid_o),
        .if_pc_o      (if_pc_o),
        .if_instr_o   (if_instr_o),
        .if_exc_o     (if_exc_o),
        .if_cause_o   (if_cause_o)
    );

    icache i_icache (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lk             (ic_if),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_req_addr_o (mem_req_addr_o),
        .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_ready_o(mem_rsp_ready_o),
        .mem_rsp_data_i (mem_rsp_data_i),
        .mem_rsp_error_i(mem_rsp_error_i),
        .hit_count_o    (hit_count_o),
        .miss_count_o   (miss_count_o)
    );

endmodule

/* bench/fetch_assert.sv */
// Handshake protocol checker
// Valid must hold with stable data while the receiver stalls
module fetch_assert
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  valid_i,
    input  logic  ready_i,
    // Entry may be dropped without a transfer
    input  logic  kill_i,
    input  addr_t data_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Stalled transfer keeps valid and address
    hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i && !ready_i && !kill_i |=> valid_i && $stable(data_i))
        else $error("valid dropped or data changed while stalled");

    // A killed entry is gone after the next edge
    kill_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
        kill_i |=> !valid_i)
        else $error("valid still set after a kill");

endmodule

// Memory request channel of the cache
bind icache fetch_assert i_req_assert (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(mem_req_valid_o),
    .ready_i(mem_req_ready_i),
    .kill_i (1'b0),
    .data_i (mem_req_addr_o)
);

// IF/ID register toward decode that a flush may kill
bind fetch_stage fetch_assert i_ifid_assert (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(if_valid_o),
    .ready_i(!hold_i),
    .kill_i (flush_i),
    .data_i (if_pc_o)
);

/* bench/fetch_tb.sv */
// Fetch front end testbench
// Random hold, redirect and predictor training checked against a reference model
module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk_i = 1'b0;
    logic rst_ni, hold_i, flush_i, inval_i, redirect_en_i;
    addr_t redirect_pc_i;
    logic bp_valid_i, bp_taken_i, bp_is_branch_i;
    addr_t bp_pc_i, bp_target_i;
    logic mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i, mem_rsp_ready_o, mem_rsp_error_i;
    addr_t mem_req_addr_o;
    word_t mem_rsp_data_i;
    logic if_valid_o, if_exc_o;
    addr_t if_pc_o;
    word_t if_instr_o;
    cause_t if_cause_o;
    count_t hit_count_o, miss_count_o;

    // Reference model state
    addr_t exp_pc;
    logic halted;
    int entry_cnt;
    count_t hits_exp, sh_miss, miss_base;
    logic [31:0] stim_rng, mem_rng;
    // Shadow predictor
    logic sh_v [BTB_LINES];
    btb_tag_t sh_tag [BTB_LINES];
    addr_t sh_tgt [BTB_LINES];
    logic [1:0] sh_cnt [BTB_LINES];
    // Shadow cache tags
    logic ic_v [IC_LINES];
    ic_tag_t ic_tag [IC_LINES];

    fetch_top i_dut (.*);

    always #20 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Memory content
    function automatic word_t mem_hash(input addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    // Access fault region
    function automatic logic in_err(input addr_t a);
        return a[31:8] == 24'h000009;
    endfunction

    function automatic addr_t predict_next(input addr_t pc);
        btb_idx_t bi;
        bi = pc[4:2];
        if (sh_v[bi] && sh_tag[bi] == pc[31:5] && sh_cnt[bi][1]) begin
            return sh_tgt[bi];
        end
        return pc + 32'd4;
    endfunction

    task automatic check_val(input string name, input logic [31:0] act_v,
                             input logic [31:0] exp_v);
        if (act_v !== exp_v) begin
            $display("Error: %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error: %0t ns %s", $time, why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // New entry when valid after a cycle without hold
    task automatic check_entry();
        ic_idx_t ci;
        ci = if_pc_o[5:2];
        if (if_valid_o && !hold_i) begin
            if (halted) begin
                abort_run("instruction fetched after an exception without a redirect");
            end else begin
                check_val("if_pc_o", if_pc_o, exp_pc);
                if (exp_pc[1:0] != 2'b00 || in_err(exp_pc)) begin
                    check_val("if_exc_o", 32'(if_exc_o), 32'd1);
                    check_val("if_cause_o", 32'(if_cause_o),
                              (exp_pc[1:0] != 2'b00) ? 32'd0 : 32'd1);
                    check_val("if_instr_o", if_instr_o, NOP_INSTR);
                    halted = 1'b1;
                end else begin
                    check_val("if_exc_o", 32'(if_exc_o), 32'd0);
                    check_val("if_instr_o", if_instr_o, mem_hash(if_pc_o));
                    hits_exp++;
                    if (!(ic_v[ci] && ic_tag[ci] == if_pc_o[31:6])) begin
                        sh_miss++;
                        ic_v[ci] = 1'b1;
                        ic_tag[ci] = if_pc_o[31:6];
                    end
                    exp_pc = predict_next(exp_pc);
                end
                entry_cnt++;
            end
        end
        check_val("hit_count_o", hit_count_o, hits_exp);
    endtask

    // Sample 1 ns after the edge and return at the 2 ns drive point
    task automatic tick();
        @(posedge clk_i);
        #1;
        check_entry();
        #1;
    endtask

    task automatic wait_entries(input int n, input int limit);
        int target;
        int cycles;
        target = entry_cnt + n;
        cycles = 0;
        while (entry_cnt < target) begin
            if (cycles >= limit) begin
                abort_run("timed out waiting for a fetched instruction");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    // Stall fetch until the refill FSM is back in IDLE
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        hold_i = 1'b1;
        tick();
        while (mem_req_valid_o || mem_rsp_ready_o) begin
            if (cycles >= 100) begin
                abort_run("memory refill did not finish");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic redirect(input addr_t target);
        hold_i = 1'b0;
        flush_i = 1'b1;
        redirect_en_i = 1'b1;
        redirect_pc_i = target;
        exp_pc = target;
        halted = 1'b0;
        tick();
        flush_i = 1'b0;
        redirect_en_i = 1'b0;
    endtask

    // Update the shadow table and pulse the update port under hold
    task automatic train(input addr_t pc, input logic taken, input addr_t target,
                         input logic is_br);
        btb_idx_t bi;
        logic hit;
        bi = pc[4:2];
        hit = sh_v[bi] && sh_tag[bi] == pc[31:5];
        if (is_br && hit) begin
            if (taken) begin
                if (sh_cnt[bi] != 2'd3) sh_cnt[bi] = sh_cnt[bi] + 2'd1;
                sh_tgt[bi] = target;
            end else if (sh_cnt[bi] != 2'd0) begin
                sh_cnt[bi] = sh_cnt[bi] - 2'd1;
            end
        end else if (is_br) begin
            sh_v[bi] = 1'b1;
            sh_tag[bi] = pc[31:5];
            sh_tgt[bi] = target;
            sh_cnt[bi] = taken ? 2'd2 : 2'd1;
        end else if (hit) begin
            sh_v[bi] = 1'b0;
        end
        hold_i = 1'b1;
        bp_valid_i = 1'b1;
        bp_pc_i = pc;
        bp_taken_i = taken;
        bp_target_i = target;
        bp_is_branch_i = is_br;
        tick();
        bp_valid_i = 1'b0;
    endtask

    task automatic clear_shadow_cache();
        for (int i = 0; i < IC_LINES; i++) ic_v[i] = 1'b0;
    endtask

    task automatic pulse_inval();
        inval_i = 1'b1;
        tick();
        inval_i = 1'b0;
        clear_shadow_cache();
    endtask

    ////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////
    initial begin
        logic busy;
        logic req_seen;
        int delay;
        addr_t req_addr;
        busy = 1'b0;
        req_seen = 1'b0;
        delay = 0;
        req_addr = '0;
        mem_rng = xorshift(32'd81);
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i = '0;
        mem_rsp_error_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #2;
            // Response was taken at this edge because rsp ready is high in WAIT
            if (mem_rsp_valid_i) begin
                mem_rsp_valid_i = 1'b0;
                busy = 1'b0;
            end else if (req_seen) begin
                req_seen = 1'b0;
                busy = 1'b1;
                delay = int'(mem_rng[9:8]);
            end
            // Response ready only while the one request is outstanding
            check_val("mem_rsp_ready_o", 32'(mem_rsp_ready_o), 32'(busy));
            if (busy && !mem_rsp_valid_i) begin
                if (delay == 0) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_rsp_data_i = mem_hash(req_addr);
                    mem_rsp_error_i = in_err(req_addr);
                end else begin
                    delay--;
                end
            end
            mem_rng = xorshift(mem_rng);
            mem_req_ready_i = mem_rng[0] | mem_rng[1];
            if (mem_req_valid_o && mem_req_ready_i) begin
                req_seen = 1'b1;
                req_addr = mem_req_addr_o;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        rst_ni = 1'b0;
        hold_i = 1'b0;
        flush_i = 1'b0;
        inval_i = 1'b0;
        redirect_en_i = 1'b0;
        redirect_pc_i = '0;
        bp_valid_i = 1'b0;
        bp_pc_i = '0;
        bp_taken_i = 1'b0;
        bp_target_i = '0;
        bp_is_branch_i = 1'b0;
        stim_rng = 32'd81;
        exp_pc = RESET_VECTOR;
        halted = 1'b0;
        entry_cnt = 0;
        hits_exp = '0;
        sh_miss = '0;
        clear_shadow_cache();
        for (int i = 0; i < BTB_LINES; i++) sh_v[i] = 1'b0;

        repeat (16) @(posedge clk_i);
        #2;
        check_val("if_valid_o", 32'(if_valid_o), 32'd0);
        check_val("if_exc_o", 32'(if_exc_o), 32'd0);
        check_val("mem_req_valid_o", 32'(mem_req_valid_o), 32'd0);
        check_val("mem_rsp_ready_o", 32'(mem_rsp_ready_o), 32'd0);
        check_val("hit_count_o", hit_count_o, 32'd0);
        check_val("miss_count_o", miss_count_o, 32'd0);
        rst_ni = 1'b1;
        wait_entries(1, 200);

        // Taken prediction that is weakened and then removed
        train(32'h200, 1'b1, 32'h340, 1'b1);
        redirect(32'h200);
        wait_entries(2, 200);
        check_val("if_pc_o", if_pc_o, 32'h340);
        train(32'h200, 1'b0, 32'h340, 1'b1);
        redirect(32'h200);
        wait_entries(2, 200);
        check_val("if_pc_o", if_pc_o, 32'h204);
        train(32'h200, 1'b1, 32'h340, 1'b1);
        train(32'h200, 1'b0, 32'h0, 1'b0);
        redirect(32'h200);
        wait_entries(2, 200);
        check_val("if_pc_o", if_pc_o, 32'h204);

        // Random hold, redirects and training inside 0x100..0x1FC
        repeat (400) begin
            stim_rng = xorshift(stim_rng);
            if (stim_rng[3:0] == 4'd0) begin
                train({23'd0, 1'b1, stim_rng[11:6], 2'b00}, stim_rng[4],
                      {23'd0, 1'b1, stim_rng[19:14], 2'b00}, stim_rng[5] | stim_rng[12]);
            end else if (stim_rng[8:4] == 5'd1) begin
                redirect({23'd0, 1'b1, stim_rng[27:22], 2'b00});
            end else begin
                hold_i = (stim_rng[21:20] == 2'b00);
                tick();
            end
        end

        // Loop replay for the counters
        wait_idle();
        pulse_inval();
        sh_miss = '0;
        miss_base = miss_count_o;
        repeat (3) begin
            redirect(32'h600);
            wait_entries(8, 400);
        end
        wait_idle();
        check_val("miss_count_o", miss_count_o - miss_base, sh_miss);
        pulse_inval();
        redirect(32'h600);
        wait_entries(8, 400);
        wait_idle();
        check_val("miss_count_o", miss_count_o - miss_base, sh_miss);

        // Access fault and misaligned target each halt fetch
        redirect(32'h900);
        wait_entries(1, 200);
        repeat (20) tick();
        redirect(32'h102);
        wait_entries(1, 200);
        repeat (20) tick();
        redirect(32'h600);
        wait_entries(1, 200);

        hold_i = 1'b1;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* compile.f */
src/fetch_pkg.sv
src/fetch_intf.sv
src/branch_predictor.sv
src/icache.sv
src/fetch_stage.sv
src/fetch_top.sv
bench/fetch_assert.sv
bench/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch front end simulation with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module fetch_tb -f compile.f -o fetch_sim

./obj_dir/fetch_sim 2>&1 | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"
